// ==== narnet.f ====
hw/narnet_pkg.sv
hw/weight_if.sv
hw/weight_loader.sv
hw/tap_decode.sv
hw/neuron_execute.sv
hw/narnet_result.sv
hw/narnet.sv
tb/tb_clock.sv
tb/narnet_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module narnet_tb \
		-f narnet.f -Mdir obj_dir -o narnet_sim
	./obj_dir/narnet_sim | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/narnet_weights.mem ====
00
0a
fb
00
03
10
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
20
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
f0
00
00
00
00
00
00
00
00
00
00
00
00
00
10
10
10
10
00
08
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
00
e0
02
10
f0
20
08
f8

// ==== tb/narnet_stim.txt ====
// sample expected_y_out, both decimal
// expected values follow the delay line of accepted samples only
5 -192
-3 -504
100 2040
-128 -4328
127 1480
20 3200
-7 -4888
64 1312
-90 -4016
1 96
0 2416
33 -296
-64 -2376
12 360
-1 1176
80 912
-50 -2544
9 -40

// ==== tb/narnet_tb.sv ====
`timescale 1ns/1ps

module narnet_tb import narnet_pkg::*; ();
        localparam int LOAD_CYCLES    = 91;
        localparam int RESULT_LATENCY = 19;

        logic    clk;
        logic    rst;
        sample_t x_in;
        logic    x_ready;
        y_t      y_out;
        logic    y_valid;
        logic    busy;
        logic    weights_ready;

        int          samples [$];
        int          expected [$];
        bit          stim_loaded;
        logic [31:0] lfsr;

        tb_clock u_clock (.clk(clk));

        narnet #(.N_NEURONS(5), .N_TAPS(16)) dut (
                .clk(clk), .rst(rst), .x_in(x_in), .x_ready(x_ready),
                .y_out(y_out), .y_valid(y_valid), .busy(busy),
                .weights_ready(weights_ready)
        );

        task automatic abort_run(input string reason);
                $display("%s", reason);
                $display("Simulation FAILED");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic expect_value(input string name, input logic signed [63:0] got,
                                    input logic signed [63:0] want);
                assert (got === want) else begin
                        abort_run($sformatf("MISMATCH at %0t: %s = %0d, expected %0d",
                                            $time, name, got, want));
                end
        endtask

        // x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic random_bits(input int n, output int value);
                value = 0;
                for (int k = 0; k < n; k++) begin
                        lfsr  = lfsr_next(lfsr);
                        value = (value << 1) | int'(lfsr[0]);
                end
        endtask

        task automatic idle_cycles(input int n);
                repeat (n) begin
                        @(posedge clk);
                        @(negedge clk);
                        expect_value("busy", busy, 0);
                        expect_value("y_valid", y_valid, 0);
                end
        endtask

        task automatic read_stimulus();
                int fd;
                int smp;
                int want;
                logic [8*128-1:0] line;
                fd = $fopen("tb/narnet_stim.txt", "r");
                if (fd == 0) begin
                        abort_run("could not open tb/narnet_stim.txt");
                end else begin
                        while (!$feof(fd)) begin
                                line = '0;
                                // comment lines do not scan as two numbers
                                if ($fgets(line, fd) != 0 &&
                                    $sscanf(line, "%d %d", smp, want) == 2) begin
                                        samples.push_back(smp);
                                        expected.push_back(want);
                                end
                        end
                        $fclose(fd);
                        if (samples.size() == 0) begin
                                abort_run("tb/narnet_stim.txt holds no samples");
                        end
                end
        endtask

        initial begin
                int gap;
                int count;
                bit done;
                rst     = 1'b1;
                x_in    = '0;
                x_ready = 1'b0;
                lfsr    = 32'h34fa;
                read_stimulus();
                stim_loaded = 1'b1;

                // rst is sampled high on 16 edges
                for (int k = 0; k < 16; k++) begin
                        @(posedge clk);
                        if (k == 15) begin
                                rst <= 1'b0;
                        end
                        @(negedge clk);
                        expect_value("weights_ready", weights_ready, 0);
                        expect_value("busy", busy, 0);
                        expect_value("y_valid", y_valid, 0);
                end

                // early strobe while the weights load
                count = 0;
                done  = 1'b0;
                while (!done) begin
                        @(posedge clk);
                        count++;
                        x_ready <= (count == 10);
                        x_in    <= 8'sd100;
                        @(negedge clk);
                        expect_value("busy", busy, 0);
                        expect_value("y_valid", y_valid, 0);
                        done = weights_ready;
                end
                expect_value("weights_ready rise cycle", count, LOAD_CYCLES);
                idle_cycles(24);

                for (int i = 0; i < samples.size(); i++) begin
                        @(posedge clk);
                        x_in    <= sample_t'(samples[i]);
                        x_ready <= 1'b1;
                        // accepting edge
                        @(posedge clk);
                        x_ready <= 1'b0;
                        @(negedge clk);
                        expect_value("busy", busy, 1);
                        count = 0;
                        done  = 1'b0;
                        while (!done && count <= RESULT_LATENCY) begin
                                @(posedge clk);
                                count++;
                                // stray strobe in the middle of some computations
                                if (i % 5 == 2) begin
                                        x_ready <= (count == 5);
                                        x_in    <= 8'sd77;
                                end
                                @(negedge clk);
                                done = y_valid;
                                if (!done) begin
                                        expect_value("busy", busy, 1);
                                end
                        end
                        expect_value("y_valid latency", count, RESULT_LATENCY);
                        expect_value("busy", busy, 0);
                        expect_value("weights_ready", weights_ready, 1);
                        expect_value("y_out", y_out, expected[i]);
                        random_bits(3, gap);
                        idle_cycles(gap + 1);
                end
                $display("Simulation PASSED");
                $finish;
        end

        initial begin
                wait (stim_loaded);
                repeat (samples.size() * 40 + 200) begin
                        @(posedge clk);
                end
                abort_run("timeout: the run went past its cycle budget");
        end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
        parameter int HALF_PERIOD = 2
) (
        output logic clk
);
        initial begin
                clk = 1'b0;
        end

        always #(HALF_PERIOD) clk = ~clk;

endmodule

// ==== hw/narnet.sv ====
`timescale 1ns/1ps

module narnet import narnet_pkg::*; #(
        parameter int N_NEURONS = 5,
        parameter int N_TAPS    = 16
) (
        input  logic    clk,
        input  logic    rst,
        input  sample_t x_in,
        input  logic    x_ready,
        output y_t      y_out,
        output logic    y_valid,
        output logic    busy,
        output logic    weights_ready
);
        logic    start;
        sample_t taps [N_TAPS];
        logic    acc_valid;
        acc_t    acc [N_NEURONS];

        weight_if #(.N_NEURONS(N_NEURONS), .N_TAPS(N_TAPS)) wts ();

        assign weights_ready = wts.weights_ready;

        weight_loader #(.N_NEURONS(N_NEURONS), .N_TAPS(N_TAPS)) u_loader (
                .clk(clk), .rst(rst), .wts(wts.loader)
        );

        // result pulse doubles as the done input
        tap_decode #(.N_TAPS(N_TAPS)) u_decode (
                .clk(clk), .rst(rst), .x_in(x_in), .x_ready(x_ready),
                .weights_ready(wts.weights_ready), .done(y_valid),
                .busy(busy), .start(start), .taps(taps)
        );

        neuron_execute #(.N_NEURONS(N_NEURONS), .N_TAPS(N_TAPS)) u_execute (
                .clk(clk), .rst(rst), .wts(wts.execute), .start(start),
                .taps(taps), .acc_valid(acc_valid), .acc(acc)
        );

        narnet_result #(.N_NEURONS(N_NEURONS)) u_result (
                .clk(clk), .rst(rst), .wts(wts.result), .acc_valid(acc_valid),
                .acc(acc), .y_out(y_out), .y_valid(y_valid)
        );

endmodule

// ==== hw/narnet_result.sv ====
`timescale 1ns/1ps

module narnet_result import narnet_pkg::*; #(
        parameter int N_NEURONS = 5
) (
        input  logic     clk,
        input  logic     rst,
        weight_if.result wts,
        input  logic     acc_valid,
        input  acc_t     acc [N_NEURONS],
        output y_t       y_out,
        output logic     y_valid
);
        sample_t hidden [N_NEURONS];
        logic hid_valid;
        y_t y_sum;

        // drop the fraction, then clamp
        function automatic sample_t saturate(acc_t a);
                acc_t s;
                s = a >>> FRAC_BITS;
                if (s > HIDDEN_MAX) begin
                        return sample_t'(HIDDEN_MAX);
                end
                if (s < HIDDEN_MIN) begin
                        return sample_t'(HIDDEN_MIN);
                end
                return sample_t'(s);
        endfunction

        always_comb begin
                y_sum = y_t'(wts.b2) <<< FRAC_BITS;
                for (int n = 0; n < N_NEURONS; n++) begin
                        y_sum = y_sum + y_t'(wts.w2[n] * hidden[n]);
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        hid_valid <= 1'b0;
                        y_valid   <= 1'b0;
                end else begin
                        hid_valid <= acc_valid;
                        y_valid   <= hid_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (acc_valid) begin
                        for (int n = 0; n < N_NEURONS; n++) begin
                                hidden[n] <= saturate(acc[n]);
                        end
                end
                if (hid_valid) begin
                        y_out <= y_sum;
                end
        end

        // y_valid is a single-cycle pulse
        assert property (@(posedge clk) disable iff (rst) y_valid |=> !y_valid);

endmodule

// ==== hw/neuron_execute.sv ====
`timescale 1ns/1ps

module neuron_execute import narnet_pkg::*; #(
        parameter int N_NEURONS = 5,
        parameter int N_TAPS    = 16
) (
        input  logic      clk,
        input  logic      rst,
        weight_if.execute wts,
        input  logic      start,
        input  sample_t   taps [N_TAPS],
        output logic      acc_valid,
        output acc_t      acc [N_NEURONS]
);
        localparam int IDX_W = $clog2(N_TAPS);

        logic [IDX_W-1:0] idx;
        logic running;
        logic last_tap;

        assign last_tap = (idx == IDX_W'(N_TAPS - 1));

        always_ff @(posedge clk) begin
                if (rst) begin
                        running   <= 1'b0;
                        idx       <= '0;
                        acc_valid <= 1'b0;
                end else begin
                        acc_valid <= running & last_tap;
                        if (start) begin
                                running <= 1'b1;
                                idx     <= '0;
                        end else if (running) begin
                                idx <= idx + 1'b1;
                                if (last_tap) begin
                                        running <= 1'b0;
                                end
                        end
                end
        end

        // bias preset on start, then one tap per cycle for all neurons
        always_ff @(posedge clk) begin
                for (int n = 0; n < N_NEURONS; n++) begin
                        if (start) begin
                                acc[n] <= acc_t'(wts.b1[n]) <<< FRAC_BITS;
                        end else if (running) begin
                                acc[n] <= acc[n] + acc_t'(wts.w1[n][idx] * taps[idx]);
                        end
                end
        end

        assert property (@(posedge clk) disable iff (rst) start |-> wts.weights_ready);

endmodule

// ==== hw/tap_decode.sv ====
`timescale 1ns/1ps

module tap_decode import narnet_pkg::*; #(
        parameter int N_TAPS = 16
) (
        input  logic    clk,
        input  logic    rst,
        input  sample_t x_in,
        input  logic    x_ready,
        input  logic    weights_ready,
        input  logic    done,
        output logic    busy,
        output logic    start,
        output sample_t taps [N_TAPS]
);
        logic busy_q;
        logic accept;

        // busy drops in the cycle the result comes out
        assign busy   = busy_q & ~done;
        assign accept = x_ready & ~busy & weights_ready;

        always_ff @(posedge clk) begin
                if (rst) begin
                        busy_q <= 1'b0;
                        start  <= 1'b0;
                end else begin
                        start <= accept;
                        if (accept) begin
                                busy_q <= 1'b1;
                        end else if (done) begin
                                busy_q <= 1'b0;
                        end
                end
        end

        // tap 0 is the newest sample
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int t = 0; t < N_TAPS; t++) begin
                                taps[t] <= '0;
                        end
                end else if (accept) begin
                        taps[0] <= x_in;
                        for (int t = 1; t < N_TAPS; t++) begin
                                taps[t] <= taps[t-1];
                        end
                end
        end

        // only one sample in flight
        assert property (@(posedge clk) disable iff (rst) start |-> !$past(busy));

endmodule

// ==== hw/weight_loader.sv ====
`timescale 1ns/1ps

module weight_loader import narnet_pkg::*; #(
        parameter int N_NEURONS = 5,
        parameter int N_TAPS    = 16
) (
        input  logic      clk,
        input  logic      rst,
        weight_if.loader  wts
);
        // rom layout, in load order
        localparam int W1_BASE = N_NEURONS;
        localparam int B2_ADDR = W1_BASE + N_NEURONS * N_TAPS;
        localparam int W2_BASE = B2_ADDR + 1;
        localparam int N_WORDS = W2_BASE + N_NEURONS;
        localparam int ADDR_W  = $clog2(N_WORDS);

        weight_t rom [N_WORDS];
        logic [ADDR_W-1:0] addr;
        weight_t word;

        initial begin
                $readmemh("hw/narnet_weights.mem", rom);
        end

        assign word = rom[addr];

        always_ff @(posedge clk) begin
                if (rst) begin
                        addr <= '0;
                        wts.weights_ready <= 1'b0;
                end else if (!wts.weights_ready) begin
                        addr <= addr + 1'b1;
                        if (int'(addr) == N_WORDS - 1) begin
                                wts.weights_ready <= 1'b1;
                        end
                end
        end

        // address decode into the weight registers
        always_ff @(posedge clk) begin
                if (!wts.weights_ready) begin
                        for (int n = 0; n < N_NEURONS; n++) begin
                                if (int'(addr) == n) begin
                                        wts.b1[n] <= word;
                                end
                                for (int t = 0; t < N_TAPS; t++) begin
                                        if (int'(addr) == W1_BASE + n * N_TAPS + t) begin
                                                wts.w1[n][t] <= word;
                                        end
                                end
                                if (int'(addr) == W2_BASE + n) begin
                                        wts.w2[n] <= word;
                                end
                        end
                        if (int'(addr) == B2_ADDR) begin
                                wts.b2 <= word;
                        end
                end
        end

        // once loaded, the weights stay until the next reset
        assert property (@(posedge clk) $fell(wts.weights_ready) |-> $past(rst));

endmodule

// ==== hw/weight_if.sv ====
`timescale 1ns/1ps

interface weight_if import narnet_pkg::*; #(
        parameter int N_NEURONS = 5,
        parameter int N_TAPS    = 16
) ();
        weight_t b1 [N_NEURONS];
        weight_t w1 [N_NEURONS][N_TAPS];
        weight_t b2;
        weight_t w2 [N_NEURONS];
        logic    weights_ready;

        modport loader  (output b1, output w1, output b2, output w2, output weights_ready);
        modport execute (input b1, input w1, input weights_ready);
        modport result  (input b2, input w2);

endinterface

// ==== hw/narnet_pkg.sv ====
package narnet_pkg;

        localparam int SAMPLE_W = 8;
        localparam int WEIGHT_W = 8;
        localparam int ACC_W    = 20;
        localparam int Y_W      = 32;

        // input sample, also the tap and hidden value width
        typedef logic signed [SAMPLE_W-1:0] sample_t;

        // weights and biases are Q3.4
        typedef logic signed [WEIGHT_W-1:0] weight_t;

        // hidden-layer accumulator
        typedef logic signed [ACC_W-1:0] acc_t;

        // network output
        typedef logic signed [Y_W-1:0] y_t;

        localparam int FRAC_BITS  = 4;

        // symmetric clamp in place of tanh
        localparam int HIDDEN_MAX = 127;
        localparam int HIDDEN_MIN = -127;

endpackage
